/* hdl/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// byte address and word widths
`define MEM_ADDR_W 16
`define MEM_DATA_W 16

// tag in bits 15..11, index in 10..3, word in 2..1
`define TAG_W 5
`define INDEX_W 8
`define WORD_W 2

// one bank per word of a line
`define LINE_WORDS 4

// bank timing
`define BANK_BUSY 4
`define MEM_RD_LAT 2

`endif

/* hdl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

   // cache controller FSM
   typedef enum logic [3:0] {
      IDLE      = 4'd0,
      COMP1     = 4'd1,
      WB        = 4'd2,
      ALLOC     = 4'd3,
      FILL_WAIT = 4'd4,
      COMP2     = 4'd5
   } ctrl_state_e;

   // main memory opcode
   typedef enum logic [1:0] {
      MEM_NOP = 2'd0,
      MEM_RD  = 2'd1,
      MEM_WR  = 2'd2
   } mem_op_e;

endpackage

`default_nettype wire

/* hdl/cache_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module cache_array (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   enable,
   input  logic                   comp,
   input  logic                   write,
   input  logic                   valid_in,
   input  logic [`TAG_W-1:0]      tag_in,
   input  logic [`INDEX_W-1:0]    index,
   input  logic [`WORD_W-1:0]     word,
   input  logic [`MEM_DATA_W-1:0] data_in,
   output logic                   hit,
   output logic                   dirty,
   output logic                   valid,
   output logic [`TAG_W-1:0]      tag_out,
   output logic [`MEM_DATA_W-1:0] data_out
);

   localparam int LINES = 1 << `INDEX_W;

   logic [`TAG_W-1:0]             tag_mem [LINES];
   logic [`MEM_DATA_W-1:0]        data_mem [LINES * `LINE_WORDS];
   logic [LINES-1:0]              valid_bits;
   logic [LINES-1:0]              dirty_bits;
   logic [`INDEX_W+`WORD_W-1:0]   waddr;
   logic                          wr_cmp;
   logic                          wr_acc;

   assign waddr    = {index, word};
   assign tag_out  = tag_mem[index];
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign data_out = data_mem[waddr];
   assign hit      = enable && valid && (tag_out == tag_in);

   // compare write only lands on a hit, access write always lands
   assign wr_cmp = enable && write && comp && hit;
   assign wr_acc = enable && write && !comp;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (wr_cmp) begin
         dirty_bits[index] <= 1'b1;
      end else if (wr_acc) begin
         valid_bits[index] <= valid_in;
         dirty_bits[index] <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_acc) begin
         tag_mem[index] <= tag_in;
      end
      if (wr_cmp || wr_acc) begin
         data_mem[waddr] <= data_in;
      end
   end

endmodule

`default_nettype wire

/* hdl/banked_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module banked_mem (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`MEM_ADDR_W-1:0] mem_addr,
   input  logic [`MEM_DATA_W-1:0] mem_wdata,
   input  mem_pkg::mem_op_e       mem_op,
   output logic [`MEM_DATA_W-1:0] mem_rdata,
   output logic                   stall
);

   import mem_pkg::*;

   localparam int WORDS  = 1 << (`MEM_ADDR_W - 1);
   localparam int BUSY_W = $clog2(`BANK_BUSY + 1);

   logic [`MEM_DATA_W-1:0] mem [WORDS];
   logic [BUSY_W-1:0]      busy [`LINE_WORDS];
   logic [`MEM_DATA_W-1:0] rd_pipe [`MEM_RD_LAT];
   logic [`MEM_ADDR_W-2:0] waddr;
   logic [`WORD_W-1:0]     bank;
   logic                   accept;

   assign waddr     = mem_addr[`MEM_ADDR_W-1:1];
   assign bank      = mem_addr[1 +: `WORD_W];
   assign stall     = (mem_op != MEM_NOP) && (busy[bank] != '0);
   assign accept    = (mem_op != MEM_NOP) && !stall;
   assign mem_rdata = rd_pipe[`MEM_RD_LAT-1];

   // memory starts at zero
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (accept && mem_op == MEM_WR) begin
         mem[waddr] <= mem_wdata;
      end
   end

   // per-bank recovery timers
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < `LINE_WORDS; b++) begin
            busy[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `LINE_WORDS; b++) begin
            if (accept && bank == `WORD_W'(b)) begin
               busy[b] <= BUSY_W'(`BANK_BUSY);
            end else if (busy[b] != '0) begin
               busy[b] <= busy[b] - 1'b1;
            end
         end
      end
   end

   // fixed read latency
   always_ff @(posedge clk) begin
      if (accept && mem_op == MEM_RD) begin
         rd_pipe[0] <= mem[waddr];
      end
      for (int s = 1; s < `MEM_RD_LAT; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module cache_ctrl (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   rd,
   input  logic                   wr,
   input  logic [`MEM_ADDR_W-1:0] addr,
   input  logic [`MEM_DATA_W-1:0] data_in,
   input  logic                   hit,
   input  logic                   dirty,
   input  logic                   valid,
   input  logic [`TAG_W-1:0]      tag_out,
   input  logic [`MEM_DATA_W-1:0] c_rdata,
   input  logic [`MEM_DATA_W-1:0] mem_rdata,
   input  logic                   stall,
   output logic                   cache_enable,
   output logic                   comp,
   output logic                   c_write,
   output logic                   valid_in,
   output logic [`TAG_W-1:0]      tag_in,
   output logic [`INDEX_W-1:0]    index,
   output logic [`WORD_W-1:0]     word,
   output logic [`MEM_DATA_W-1:0] c_wdata,
   output logic [`MEM_ADDR_W-1:0] mem_addr,
   output logic [`MEM_DATA_W-1:0] mem_wdata,
   output mem_pkg::mem_op_e       mem_op,
   output logic [`MEM_DATA_W-1:0] data_out,
   output logic                   done,
   output logic                   cache_hit,
   output logic                   err
);

   import mem_pkg::*;

   ctrl_state_e                          state;
   ctrl_state_e                          next_state;
   logic [`TAG_W-1:0]                    req_tag;
   logic [`INDEX_W-1:0]                  req_index;
   logic [`WORD_W-1:0]                   req_word;
   logic [`WORD_W-1:0]                   cnt;
   logic                                 cnt_inc;
   logic                                 push;
   logic                                 err_set;
   logic [`MEM_RD_LAT-1:0]               pend_vld;
   logic [`MEM_RD_LAT-1:0][`WORD_W-1:0]  pend_word;
   logic                                 fill;
   logic [`WORD_W-1:0]                   fill_word;

   // request fields straight from the held inputs
   assign req_tag   = addr[`MEM_ADDR_W-1 -: `TAG_W];
   assign req_index = addr[`WORD_W+1 +: `INDEX_W];
   assign req_word  = addr[1 +: `WORD_W];

   assign tag_in    = req_tag;
   assign index     = req_index;
   assign data_out  = c_rdata;
   assign fill      = pend_vld[`MEM_RD_LAT-1];
   assign fill_word = pend_word[`MEM_RD_LAT-1];

   always_comb begin
      next_state   = state;
      cache_enable = 1'b0;
      comp         = 1'b0;
      c_write      = 1'b0;
      valid_in     = 1'b0;
      word         = req_word;
      c_wdata      = data_in;
      mem_op       = MEM_NOP;
      mem_addr     = {req_tag, req_index, cnt, 1'b0};
      mem_wdata    = c_rdata;
      done         = 1'b0;
      cache_hit    = 1'b0;
      cnt_inc      = 1'b0;
      push         = 1'b0;
      err_set      = 1'b0;

      // returning read data goes into the line
      if (fill) begin
         cache_enable = 1'b1;
         c_write      = 1'b1;
         valid_in     = 1'b1;
         word         = fill_word;
         c_wdata      = mem_rdata;
      end

      case (state)
         IDLE: begin
            // err is still high on the cycle the requester sees it
            if ((rd || wr) && !err) begin
               if (addr[0]) begin
                  err_set = 1'b1;
               end else begin
                  next_state = COMP1;
               end
            end
         end
         COMP1: begin
            cache_enable = 1'b1;
            comp         = 1'b1;
            c_write      = wr;
            if (hit) begin
               done       = 1'b1;
               cache_hit  = 1'b1;
               next_state = IDLE;
            end else if (valid && dirty) begin
               next_state = WB;
            end else begin
               next_state = ALLOC;
            end
         end
         WB: begin
            // victim goes out at its own tag
            word     = cnt;
            mem_op   = MEM_WR;
            mem_addr = {tag_out, req_index, cnt, 1'b0};
            if (!stall) begin
               cnt_inc = 1'b1;
               if (cnt == '1) begin
                  next_state = ALLOC;
               end
            end
         end
         ALLOC: begin
            mem_op = MEM_RD;
            if (!stall) begin
               cnt_inc = 1'b1;
               push    = 1'b1;
               if (cnt == '1) begin
                  next_state = FILL_WAIT;
               end
            end
         end
         FILL_WAIT: begin
            if (pend_vld[`MEM_RD_LAT-2:0] == '0) begin
               next_state = COMP2;
            end
         end
         COMP2: begin
            cache_enable = 1'b1;
            comp         = 1'b1;
            c_write      = wr;
            done         = 1'b1;
            next_state   = IDLE;
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= IDLE;
         err      <= 1'b0;
         cnt      <= '0;
         pend_vld <= '0;
      end else begin
         state    <= next_state;
         err      <= err_set;
         pend_vld <= {pend_vld[`MEM_RD_LAT-2:0], push};
         if (cnt_inc) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // word numbers of reads in flight
   always_ff @(posedge clk) begin
      pend_word <= {pend_word[`MEM_RD_LAT-2:0], cnt};
   end

endmodule

`default_nettype wire

/* hdl/mem_system.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module mem_system (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [`MEM_ADDR_W-1:0] addr,
   input  logic [`MEM_DATA_W-1:0] data_in,
   input  logic                   rd,
   input  logic                   wr,
   output logic [`MEM_DATA_W-1:0] data_out,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err
);

   import mem_pkg::*;

   logic                   c_enable;
   logic                   c_comp;
   logic                   c_write;
   logic                   c_valid_in;
   logic [`TAG_W-1:0]      c_tag_in;
   logic [`INDEX_W-1:0]    c_index;
   logic [`WORD_W-1:0]     c_word;
   logic [`MEM_DATA_W-1:0] c_wdata;
   logic                   c_hit;
   logic                   c_dirty;
   logic                   c_valid;
   logic [`TAG_W-1:0]      c_tag_out;
   logic [`MEM_DATA_W-1:0] c_rdata;
   logic [`MEM_ADDR_W-1:0] mem_addr;
   logic [`MEM_DATA_W-1:0] mem_wdata;
   logic [`MEM_DATA_W-1:0] mem_rdata;
   mem_op_e                mem_op;

   cache_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .rd           (rd),
      .wr           (wr),
      .addr         (addr),
      .data_in      (data_in),
      .hit          (c_hit),
      .dirty        (c_dirty),
      .valid        (c_valid),
      .tag_out      (c_tag_out),
      .c_rdata      (c_rdata),
      .mem_rdata    (mem_rdata),
      .stall        (stall),
      .cache_enable (c_enable),
      .comp         (c_comp),
      .c_write      (c_write),
      .valid_in     (c_valid_in),
      .tag_in       (c_tag_in),
      .index        (c_index),
      .word         (c_word),
      .c_wdata      (c_wdata),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_op       (mem_op),
      .data_out     (data_out),
      .done         (done),
      .cache_hit    (cache_hit),
      .err          (err)
   );

   cache_array u_cache (
      .clk      (clk),
      .rst      (rst),
      .enable   (c_enable),
      .comp     (c_comp),
      .write    (c_write),
      .valid_in (c_valid_in),
      .tag_in   (c_tag_in),
      .index    (c_index),
      .word     (c_word),
      .data_in  (c_wdata),
      .hit      (c_hit),
      .dirty    (c_dirty),
      .valid    (c_valid),
      .tag_out  (c_tag_out),
      .data_out (c_rdata)
   );

   // stall at the top is the memory's own
   banked_mem u_mem (
      .clk       (clk),
      .rst       (rst),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_op    (mem_op),
      .mem_rdata (mem_rdata),
      .stall     (stall)
   );

endmodule

`default_nettype wire

/* tb/tb_mem_system.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mem_defs.svh"

module tb_mem_system;

   localparam int RAND_REQS   = 300;
   localparam int NUM_REQS    = RAND_REQS + 11;
   localparam int WDOG_CYCLES = NUM_REQS * 40 + 200;

   logic                   clk;
   logic                   rst;
   logic [`MEM_ADDR_W-1:0] addr;
   logic [`MEM_DATA_W-1:0] data_in;
   logic                   rd;
   logic                   wr;
   logic [`MEM_DATA_W-1:0] data_out;
   logic                   done;
   logic                   stall;
   logic                   cache_hit;
   logic                   err;

   // reference model
   logic [`MEM_DATA_W-1:0] model_mem [logic [`MEM_ADDR_W-2:0]];
   logic [`TAG_W-1:0]      model_tag [1 << `INDEX_W];
   logic                   model_valid [1 << `INDEX_W];

   // expectations for the request in flight
   logic                   req_active;
   logic                   exp_rd;
   logic                   exp_err;
   logic                   exp_hit;
   logic [`MEM_DATA_W-1:0] exp_data;
   logic [31:0]            lfsr;
   int                     cycle = 0;
   int                     start_cycle = 0;
   int                     err_idle = 0;
   int                     err_end = 0;
   int                     err_hit = 0;
   int                     err_data = 0;
   int                     err_lat = 0;
   int                     err_pulse = 0;

   mem_system u_mem_system (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // nothing moves between requests
   assert property (@(posedge clk) disable iff (rst)
      !req_active |-> !done && !cache_hit && !err && !stall)
   else begin
      err_idle++;
      $display("Error: idle outputs done=%h cache_hit=%h err=%h stall=%h",
         $sampled(done), $sampled(cache_hit), $sampled(err), $sampled(stall));
   end

   assert property (@(posedge clk) disable iff (rst) done |-> !exp_err && !err)
   else begin
      err_end++;
      $display("Error: done=%h err=%h expected err=%h",
         $sampled(done), $sampled(err), $sampled(exp_err));
   end

   assert property (@(posedge clk) disable iff (rst) err |-> exp_err)
   else begin
      err_end++;
      $display("Error: err=%h expected %h", $sampled(err), $sampled(exp_err));
   end

   assert property (@(posedge clk) disable iff (rst) done |-> cache_hit == exp_hit)
   else begin
      err_hit++;
      $display("Error: cache_hit=%h expected %h", $sampled(cache_hit), $sampled(exp_hit));
   end

   assert property (@(posedge clk) disable iff (rst) done && exp_rd |-> data_out == exp_data)
   else begin
      err_data++;
      $display("Error: data_out=%h expected %h addr=%h",
         $sampled(data_out), $sampled(exp_data), $sampled(addr));
   end

   // hits and refusals answer one cycle after the request is sampled
   assert property (@(posedge clk) disable iff (rst)
      (done && exp_hit) || err |-> cycle - start_cycle == 1)
   else begin
      err_lat++;
      $display("Error: latency=%h expected %h",
         $sampled(cycle) - $sampled(start_cycle), 1);
   end

   assert property (@(posedge clk) disable iff (rst) done || err |=> !done && !err)
   else begin
      err_pulse++;
      $display("Error: pulse held done=%h err=%h", $sampled(done), $sampled(err));
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   task automatic do_request(input logic is_wr, input logic [15:0] a, input logic [15:0] d);
      logic [`INDEX_W-1:0]    idx;
      logic [`MEM_ADDR_W-2:0] key;
      idx = a[10:3];
      key = a[15:1];
      @(posedge clk);
      #1;
      exp_rd   = !is_wr;
      exp_err  = a[0];
      exp_hit  = model_valid[idx] && (model_tag[idx] == a[15:11]);
      exp_data = model_mem.exists(key) ? model_mem[key] : '0;
      addr     = a;
      data_in  = d;
      rd       = !is_wr;
      wr       = is_wr;
      start_cycle = cycle;
      req_active  = 1'b1;
      do @(negedge clk); while (!done && !err);
      if (done && !a[0]) begin
         if (is_wr) begin
            model_mem[key] = d;
         end
         model_tag[idx]   = a[15:11];
         model_valid[idx] = 1'b1;
      end
      @(posedge clk);
      #1;
      rd         = 1'b0;
      wr         = 1'b0;
      req_active = 1'b0;
   endtask

   initial begin
      logic [15:0] op;
      logic [15:0] tsel;
      logic [15:0] isel;
      logic [15:0] wsel;
      logic [15:0] wdat;
      int          total;
      clk = 1'b0;
      rst = 1'b1;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      req_active = 1'b0;
      exp_rd = 1'b0;
      exp_err = 1'b0;
      exp_hit = 1'b0;
      exp_data = '0;
      lfsr = 32'h32b0_348d;
      for (int i = 0; i < (1 << `INDEX_W); i++) begin
         model_valid[i] = 1'b0;
         model_tag[i]   = '0;
      end
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;

      // A and B share index 0x48 under different tags
      do_request(1'b0, 16'h0a40, 16'h0000);
      do_request(1'b1, 16'h0a40, 16'hbeef);
      do_request(1'b0, 16'h0a40, 16'h0000);
      do_request(1'b1, 16'h8a40, 16'h5a5a);
      do_request(1'b0, 16'h0a40, 16'h0000);
      do_request(1'b0, 16'h8a40, 16'h0000);
      // misaligned requests are refused
      do_request(1'b0, 16'h0a41, 16'h0000);
      do_request(1'b0, 16'h0a40, 16'h0000);
      do_request(1'b1, 16'h8a43, 16'hffff);
      do_request(1'b0, 16'h8a40, 16'h0000);
      do_request(1'b0, 16'h8a42, 16'h0000);

      // two tags over four indexes
      for (int n = 0; n < RAND_REQS; n++) begin
         op   = take_bits(1);
         tsel = take_bits(1);
         isel = take_bits(2);
         wsel = take_bits(2);
         wdat = take_bits(16);
         do_request(op[0], {tsel[0] ? 5'h16 : 5'h09, 6'h0b, isel[1:0], wsel[1:0], 1'b0},
            wdat);
      end

      repeat (4) @(posedge clk);
      total = err_idle + err_end + err_hit + err_data + err_lat + err_pulse;
      $display("errors: idle %0d, end %0d, hit %0d, data %0d, latency %0d, pulse %0d, total %0d",
         err_idle, err_end, err_hit, err_data, err_lat, err_pulse, total);
      if (total == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      repeat (16 + WDOG_CYCLES) @(posedge clk);
      $display("timeout: the requests did not finish within %0d cycles", WDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/cache_array.sv
hdl/banked_mem.sv
hdl/cache_ctrl.sv
hdl/mem_system.sv
tb/tb_mem_system.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = tb_mem_system
FILELIST = filelist.f
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
